// ==== build.f ====
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_if.sv
verilog/csr_machine_regs.sv
verilog/csr_trap_ctrl.sv
verilog/csr_cycle_counter.sv
verilog/csr_read_mux.sv
verilog/csr_top.sv
tests/tb_csr_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_csr_top -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== tests/tb_csr_top.sv ====
`timescale 1ns/10ps
`include "csr_cfg.svh"

module tb_csr_top;
    import csr_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_RW       = 40;
    localparam int N_RAND     = 20;
    localparam int N_IRQ      = 60;
    localparam int N_EXC      = 30;
    localparam int N_RET      = 20;
    // Reset, then every phase by its cycles per iteration
    localparam int TEST_CYCLES = 5 + 2 + 2 * N_RW + 4 + N_RAND + 14
                               + 8 * N_IRQ + 5 * N_EXC + 5 * N_RET;
    // Causes 0, 1, 4-7, 12, 13 and 15 record the faulting value
    localparam logic [15:0] TVAL_CAUSES = 16'hB0F3;

    logic       clk_i;
    logic       rst_i;
    csr_addr_t  csr_rd_addr_i;
    csr_word_t  csr_data_o;
    logic       csr_we_i;
    csr_addr_t  csr_we_addr_i;
    csr_word_t  csr_we_data_i;
    logic       ext_irq_i;
    logic       tmr_irq_i;
    logic       sft_irq_i;
    logic       exp_vld_i;
    exc_cause_e exp_cause_i;
    csr_word_t  exp_tval_i;
    csr_word_t  next_pc_i;
    logic       mret_i;
    logic       trap_taken_o;
    csr_word_t  handler_pc_o;
    csr_word_t  return_pc_o;

    // Reference model state
    logic        ref_mie_bit;
    logic        ref_mpie;
    csr_word_t   ref_mie;
    csr_word_t   ref_mip;
    csr_word_t   ref_mtvec;
    csr_word_t   ref_mscratch;
    csr_word_t   ref_mepc;
    csr_word_t   ref_mcause;
    csr_word_t   ref_mtval;
    logic [63:0] ref_count;

    integer    seed;
    csr_addr_t rw_addrs [8];

    csr_top i_csr_top (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_rd_addr_i (csr_rd_addr_i),
        .csr_data_o    (csr_data_o),
        .csr_we_i      (csr_we_i),
        .csr_we_addr_i (csr_we_addr_i),
        .csr_we_data_i (csr_we_data_i),
        .ext_irq_i     (ext_irq_i),
        .tmr_irq_i     (tmr_irq_i),
        .sft_irq_i     (sft_irq_i),
        .exp_vld_i     (exp_vld_i),
        .exp_cause_i   (exp_cause_i),
        .exp_tval_i    (exp_tval_i),
        .next_pc_i     (next_pc_i),
        .mret_i        (mret_i),
        .trap_taken_o  (trap_taken_o),
        .handler_pc_o  (handler_pc_o),
        .return_pc_o   (return_pc_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Watchdog sized from the test length plus some slack
    initial
    begin
        #((TEST_CYCLES + 50) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
        if (exp !== act)
        begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("FAILED %s expected %b actual %b", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "bit mismatch");
        end
    endtask

    function automatic csr_word_t rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic is_write(input csr_addr_t addr);
        is_write = csr_we_i && (csr_we_addr_i == addr);
    endfunction

    // Expected software read value
    function automatic csr_word_t model_read(input csr_addr_t addr);
        case (addr)
            CSR_MSTATUS:   model_read = 32'h1800 | {24'd0, ref_mpie, 3'd0, ref_mie_bit, 3'd0};
            CSR_MIE:       model_read = ref_mie;
            CSR_MIP:       model_read = ref_mip;
            CSR_MTVEC:     model_read = ref_mtvec;
            CSR_MSCRATCH:  model_read = ref_mscratch;
            CSR_MEPC:      model_read = ref_mepc;
            CSR_MCAUSE:    model_read = ref_mcause;
            CSR_MTVAL:     model_read = ref_mtval;
            CSR_MCYCLE:    model_read = ref_count[31:0];
            CSR_CYCLE:     model_read = ref_count[31:0];
            CSR_MCYCLEH:   model_read = ref_count[63:32];
            CSR_CYCLEH:    model_read = ref_count[63:32];
            CSR_MVENDORID: model_read = `CSR_VENDOR_ID;
            CSR_MARCHID:   model_read = `CSR_ARCH_ID;
            CSR_MIMPID:    model_read = `CSR_IMP_ID;
            CSR_MHARTID:   model_read = `CSR_HART_ID;
            default:       model_read = '0;
        endcase
    endfunction

    task automatic clear_inputs();
        csr_we_i      = 1'b0;
        csr_we_addr_i = '0;
        csr_we_data_i = '0;
        ext_irq_i     = 1'b0;
        tmr_irq_i     = 1'b0;
        sft_irq_i     = 1'b0;
        exp_vld_i     = 1'b0;
        exp_cause_i   = EXC_INSTR_MISALIGN;
        exp_tval_i    = '0;
        next_pc_i     = '0;
        mret_i        = 1'b0;
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_word_t data);
        csr_we_i      = 1'b1;
        csr_we_addr_i = addr;
        csr_we_data_i = data;
    endtask

    // --------------------
    // One clock: check outputs, then advance the model at the edge
    // --------------------
    task automatic step(input string name);
        logic [2:0] pend;
        logic       irq_hit;
        logic [3:0] irq_code;
        logic       trap;
        csr_word_t  cause;
        csr_word_t  handler;
        csr_word_t  req;
        #10;
        // Global enable, then each line against its enable bit
        pend = ref_mie_bit ? ({ext_irq_i, tmr_irq_i, sft_irq_i}
                              & {ref_mie[11], ref_mie[7], ref_mie[3]}) : 3'b000;
        irq_hit  = |pend;
        irq_code = pend[2] ? 4'd11 : (pend[1] ? 4'd7 : 4'd3);
        trap     = exp_vld_i || irq_hit;
        cause    = exp_vld_i ? csr_word_t'(exp_cause_i) : {1'b1, 27'd0, irq_code};
        handler  = {ref_mtvec[31:2], 2'b00};
        if (irq_hit && !exp_vld_i && ref_mtvec[1:0] == 2'b01)
            handler = handler + {26'd0, irq_code, 2'b00};
        check_bit({name, " trap_taken"}, trap, trap_taken_o);
        check_word({name, " handler_pc"}, handler, handler_pc_o);
        check_word({name, " return_pc"}, ref_mepc, return_pc_o);
        check_word({name, " csr_data"}, model_read(csr_rd_addr_i), csr_data_o);
        req = {20'd0, ext_irq_i, 3'd0, tmr_irq_i, 3'd0, sft_irq_i, 3'd0};
        @(posedge clk_i);
        if (trap)
        begin
            ref_mpie    = ref_mie_bit;
            ref_mie_bit = 1'b0;
            ref_mepc    = next_pc_i;
            ref_mcause  = cause;
            if (exp_vld_i && TVAL_CAUSES[exp_cause_i])
                ref_mtval = exp_tval_i;
        end
        else
        begin
            if (mret_i)
            begin
                ref_mie_bit = ref_mpie;
                ref_mpie    = 1'b1;
            end
            else if (is_write(CSR_MSTATUS))
            begin
                ref_mie_bit = csr_we_data_i[3];
                ref_mpie    = csr_we_data_i[7];
            end
            if (is_write(CSR_MEPC))
                ref_mepc = csr_we_data_i;
            if (is_write(CSR_MCAUSE))
                ref_mcause = csr_we_data_i;
            if (is_write(CSR_MTVAL))
                ref_mtval = csr_we_data_i;
        end
        // Pending uses the enables from before this edge
        ref_mip = req & ref_mie;
        if (is_write(CSR_MIE))
            ref_mie = csr_we_data_i & 32'h0000_0888;
        if (is_write(CSR_MTVEC))
            ref_mtvec = csr_we_data_i;
        if (is_write(CSR_MSCRATCH))
            ref_mscratch = csr_we_data_i;
        if (is_write(CSR_MCYCLE))
            ref_count[31:0] = csr_we_data_i;
        else if (is_write(CSR_MCYCLEH))
            ref_count[63:32] = csr_we_data_i;
        else
            ref_count = ref_count + 64'd1;
        #2;
        clear_inputs();
    endtask

    initial
    begin
        csr_addr_t addr;
        csr_word_t data;
        csr_word_t sel;
        seed     = 32'h1449;
        rw_addrs = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                     CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP};
        clear_inputs();
        csr_rd_addr_i = CSR_MSTATUS;
        rst_i         = 1'b1;
        ref_mie_bit   = 1'b0;
        ref_mpie      = 1'b0;
        ref_mie       = '0;
        ref_mip       = '0;
        ref_mtvec     = '0;
        ref_mscratch  = '0;
        ref_mepc      = '0;
        ref_mcause    = '0;
        ref_mtval     = '0;
        ref_count     = '0;
        repeat (5) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        step("reset_mstatus");
        csr_rd_addr_i = CSR_MTVEC;
        step("reset_mtvec");

        // --------------------
        // Write masks, IDs, unknown addresses
        // --------------------
        for (int i = 0; i < N_RW; i++)
        begin
            data = rand_word();
            sel  = rand_word();
            addr = rw_addrs[sel[2:0]];
            // Keep mtvec in a defined mode
            if (addr == CSR_MTVEC)
                data[1] = 1'b0;
            write_csr(addr, data);
            csr_rd_addr_i = addr;
            step("csr_write");
            step("csr_readback");
        end
        csr_rd_addr_i = CSR_MVENDORID;
        step("mvendorid");
        csr_rd_addr_i = CSR_MARCHID;
        step("marchid");
        csr_rd_addr_i = CSR_MIMPID;
        step("mimpid");
        csr_rd_addr_i = CSR_MHARTID;
        step("mhartid");
        for (int i = 0; i < N_RAND; i++)
        begin
            sel           = rand_word();
            csr_rd_addr_i = sel[11:0];
            step("random_read");
        end

        // --------------------
        // Cycle counter and aliases
        // --------------------
        csr_rd_addr_i = CSR_MCYCLE;
        repeat (4) step("cycle_count");
        // Low half near wrap so the carry reaches the high half
        write_csr(CSR_MCYCLE, 32'hFFFF_FFFE);
        step("mcycle_write");
        csr_rd_addr_i = CSR_CYCLE;
        repeat (4) step("cycle_alias_lo");
        csr_rd_addr_i = CSR_CYCLEH;
        step("cycle_alias_hi");
        write_csr(CSR_MCYCLEH, rand_word());
        step("mcycleh_write");
        repeat (2) step("cycle_alias_hi");
        csr_rd_addr_i = CSR_MCYCLEH;
        step("mcycleh_read");

        // --------------------
        // Interrupt arbitration
        // --------------------
        for (int i = 0; i < N_IRQ; i++)
        begin
            data    = rand_word();
            data[1] = 1'b0;
            write_csr(CSR_MTVEC, data);
            step("irq_mtvec");
            write_csr(CSR_MIE, rand_word());
            step("irq_mie");
            data    = rand_word();
            data[3] = 1'b1;
            write_csr(CSR_MSTATUS, data);
            step("irq_mstatus");
            sel           = rand_word();
            ext_irq_i     = sel[0];
            tmr_irq_i     = sel[1];
            sft_irq_i     = sel[2];
            next_pc_i     = rand_word();
            csr_rd_addr_i = CSR_MIP;
            step("irq_request");
            // mip shows the masked requests one cycle later
            step("irq_mip");
            csr_rd_addr_i = CSR_MCAUSE;
            step("irq_mcause");
            csr_rd_addr_i = CSR_MEPC;
            step("irq_mepc");
            csr_rd_addr_i = CSR_MSTATUS;
            step("irq_mstatus_after");
        end

        // --------------------
        // Exceptions with MIE off
        // --------------------
        for (int i = 0; i < N_EXC; i++)
        begin
            data    = rand_word();
            data[3] = 1'b0;
            write_csr(CSR_MSTATUS, data);
            step("exc_mstatus");
            sel           = rand_word();
            exp_vld_i     = 1'b1;
            exp_cause_i   = exc_cause_e'(sel[3:0]);
            exp_tval_i    = rand_word();
            next_pc_i     = rand_word();
            ext_irq_i     = sel[4];
            tmr_irq_i     = sel[5];
            sft_irq_i     = sel[6];
            csr_rd_addr_i = CSR_MTVAL;
            step("exc_trap");
            step("exc_mtval");
            csr_rd_addr_i = CSR_MCAUSE;
            step("exc_mcause");
            csr_rd_addr_i = CSR_MEPC;
            step("exc_mepc");
        end

        // --------------------
        // mret, some colliding with a trap
        // --------------------
        for (int i = 0; i < N_RET; i++)
        begin
            write_csr(CSR_MSTATUS, rand_word());
            step("ret_mstatus");
            write_csr(CSR_MEPC, rand_word());
            csr_rd_addr_i = CSR_MSTATUS;
            step("ret_mepc");
            mret_i = 1'b1;
            if (i % 4 == 0)
            begin
                exp_vld_i   = 1'b1;
                exp_cause_i = EXC_ILLEGAL;
                next_pc_i   = rand_word();
            end
            step("ret_strobe");
            step("ret_mstatus_after");
            csr_rd_addr_i = CSR_MEPC;
            step("ret_mepc_after");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verilog/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// --------------------
// Datapath widths
// --------------------

// One CSR word, RV32 only
`define CSR_XLEN 32

// Full cycle counter, split into two CSR halves
`define CSR_CNT_W 64

// --------------------
// Read-only ID values
// --------------------

// Hart number of this core
`define CSR_HART_ID 0

// Zero means a non-commercial implementation
`define CSR_VENDOR_ID 0

// No registered architecture ID
`define CSR_ARCH_ID 0

// Implementation version
`define CSR_IMP_ID 0

`endif

// ==== verilog/csr_cycle_counter.sv ====
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_cycle_counter
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  csr_we_i,
    input  csr_pkg::csr_addr_t    csr_we_addr_i,
    input  csr_pkg::csr_word_t    csr_we_data_i,
    output logic [`CSR_CNT_W-1:0] count_o
);
    import csr_pkg::*;

    logic [`CSR_CNT_W-1:0] count_q;
    logic                  wr_lo;
    logic                  wr_hi;

    // Only the machine names are writable, CYCLE/CYCLEH are read aliases
    assign wr_lo = csr_we_i && (csr_we_addr_i == CSR_MCYCLE);
    assign wr_hi = csr_we_i && (csr_we_addr_i == CSR_MCYCLEH);

    // A written half loads and counting pauses for that edge
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            count_q <= '0;
        else if (wr_lo)
            count_q[`CSR_XLEN-1:0] <= csr_we_data_i;
        else if (wr_hi)
            count_q[`CSR_CNT_W-1:`CSR_XLEN] <= csr_we_data_i;
        else
            count_q <= count_q + 1'b1;
    end

    assign count_o = count_q;

    a_count_step: assert property (@(posedge clk_i) disable iff (rst_i)
        !wr_lo && !wr_hi |=> count_q == $past(count_q) + 1'b1)
        else $error("cycle counter did not advance by one");

endmodule

// ==== verilog/csr_if.sv ====
`timescale 1ns/10ps

// Architectural CSR state shared by the register block
interface csr_state_if;
    import csr_pkg::*;

    logic      mstatus_mie;
    logic      mstatus_mpie;
    csr_word_t mie;
    csr_word_t mip;
    csr_word_t mtvec;
    csr_word_t mscratch;
    csr_word_t mepc;
    csr_word_t mcause;
    csr_word_t mtval;

    modport producer (output mstatus_mie, mstatus_mpie, mie, mip, mtvec,
                      output mscratch, mepc, mcause, mtval);
    modport consumer (input mstatus_mie, mstatus_mpie, mie, mip, mtvec,
                      input mscratch, mepc, mcause, mtval);
endinterface

// Trap decision from the arbiter to the register block
interface csr_trap_if;
    import csr_pkg::*;

    logic      trap_taken;
    // Full mcause value, bit 31 flags an interrupt
    csr_word_t trap_cause;
    logic      tval_we;
    csr_word_t tval;

    modport ctrl (output trap_taken, trap_cause, tval_we, tval);
    modport regs (input trap_taken, trap_cause, tval_we, tval);
endinterface

// ==== verilog/csr_machine_regs.sv ====
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_machine_regs
(
    input  logic               clk_i,
    input  logic               rst_i,
    // Software write port
    input  logic               csr_we_i,
    input  csr_pkg::csr_addr_t csr_we_addr_i,
    input  csr_pkg::csr_word_t csr_we_data_i,
    // Return address saved on a trap
    input  csr_pkg::csr_word_t next_pc_i,
    input  logic               mret_i,
    // Raw interrupt lines
    input  logic               ext_irq_i,
    input  logic               tmr_irq_i,
    input  logic               sft_irq_i,
    csr_state_if.producer      state_o,
    csr_trap_if.regs           trap_i
);
    import csr_pkg::*;

    logic      mstatus_mie_q;
    logic      mstatus_mpie_q;
    csr_word_t mie_q;
    csr_word_t mip_q;
    csr_word_t mtvec_q;
    csr_word_t mscratch_q;
    csr_word_t mepc_q;
    csr_word_t mcause_q;
    csr_word_t mtval_q;

    csr_word_t irq_req;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    // --------------------
    // Write decode
    // --------------------
    assign wr_mstatus  = csr_we_i && (csr_we_addr_i == CSR_MSTATUS);
    assign wr_mie      = csr_we_i && (csr_we_addr_i == CSR_MIE);
    assign wr_mtvec    = csr_we_i && (csr_we_addr_i == CSR_MTVEC);
    assign wr_mscratch = csr_we_i && (csr_we_addr_i == CSR_MSCRATCH);
    assign wr_mepc     = csr_we_i && (csr_we_addr_i == CSR_MEPC);
    assign wr_mcause   = csr_we_i && (csr_we_addr_i == CSR_MCAUSE);
    assign wr_mtval    = csr_we_i && (csr_we_addr_i == CSR_MTVAL);

    // Request lines placed at MEIP/MTIP/MSIP
    always_comb
    begin
        irq_req            = '0;
        irq_req[IRQ_EXT]   = ext_irq_i;
        irq_req[IRQ_TIMER] = tmr_irq_i;
        irq_req[IRQ_SOFT]  = sft_irq_i;
    end

    // --------------------
    // mstatus MIE/MPIE
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
        end
        else if (trap_i.trap_taken)
        begin
            // Stack MIE into MPIE and mask further interrupts
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
        end
        else if (mret_i)
        begin
            mstatus_mie_q  <= mstatus_mpie_q;
            mstatus_mpie_q <= 1'b1;
        end
        else if (wr_mstatus)
        begin
            mstatus_mie_q  <= csr_we_data_i[3];
            mstatus_mpie_q <= csr_we_data_i[7];
        end
    end

    // --------------------
    // Enables, pending, vector, scratch
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mie_q      <= '0;
            mip_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end
        else
        begin
            if (wr_mie)
            begin
                // Only MEIE, MTIE and MSIE exist
                mie_q[IRQ_EXT]   <= csr_we_data_i[IRQ_EXT];
                mie_q[IRQ_TIMER] <= csr_we_data_i[IRQ_TIMER];
                mie_q[IRQ_SOFT]  <= csr_we_data_i[IRQ_SOFT];
            end
            // Pending bits trail the request lines by one cycle
            mip_q <= irq_req & mie_q;
            if (wr_mtvec)
            begin
                mtvec_q <= csr_we_data_i;
            end
            if (wr_mscratch)
            begin
                mscratch_q <= csr_we_data_i;
            end
        end
    end

    // --------------------
    // Trap record
    // --------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end
        else if (trap_i.trap_taken)
        begin
            mepc_q   <= next_pc_i;
            mcause_q <= trap_i.trap_cause;
            // mtval holds only for address-type exceptions
            if (trap_i.tval_we)
            begin
                mtval_q <= trap_i.tval;
            end
        end
        else
        begin
            if (wr_mepc)
            begin
                mepc_q <= csr_we_data_i;
            end
            if (wr_mcause)
            begin
                mcause_q <= csr_we_data_i;
            end
            if (wr_mtval)
            begin
                mtval_q <= csr_we_data_i;
            end
        end
    end

    assign state_o.mstatus_mie  = mstatus_mie_q;
    assign state_o.mstatus_mpie = mstatus_mpie_q;
    assign state_o.mie          = mie_q;
    assign state_o.mip          = mip_q;
    assign state_o.mtvec        = mtvec_q;
    assign state_o.mscratch     = mscratch_q;
    assign state_o.mepc         = mepc_q;
    assign state_o.mcause       = mcause_q;
    assign state_o.mtval        = mtval_q;

    // mtval loads only in the trap branch
    // An enable outside an exception trap would lose the fault value
    a_tval_we: assert property (@(posedge clk_i) disable iff (rst_i)
        trap_i.tval_we |-> trap_i.trap_taken && !trap_i.trap_cause[`CSR_XLEN-1])
        else $error("mtval write enable without an exception trap");

endmodule

// ==== verilog/csr_pkg.sv ====
`include "csr_cfg.svh"

package csr_pkg;

    // Data word and raw 12-bit address
    typedef logic [`CSR_XLEN-1:0] csr_word_t;
    typedef logic [11:0]          csr_addr_t;

    // Implemented CSR addresses, also the decoder opcode set
    typedef enum logic [11:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MCYCLEH   = 12'hB80,
        CSR_CYCLE     = 12'hC00,
        CSR_CYCLEH    = 12'hC80,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    // Synchronous exception codes
    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGN = 4'd0,
        EXC_INSTR_FAULT    = 4'd1,
        EXC_ILLEGAL        = 4'd2,
        EXC_BREAKPOINT     = 4'd3,
        EXC_LOAD_MISALIGN  = 4'd4,
        EXC_LOAD_FAULT     = 4'd5,
        EXC_STORE_MISALIGN = 4'd6,
        EXC_STORE_FAULT    = 4'd7,
        EXC_ECALL_U        = 4'd8,
        EXC_ECALL_S        = 4'd9,
        EXC_RSVD_10        = 4'd10,
        EXC_ECALL_M        = 4'd11,
        EXC_INSTR_PAGE     = 4'd12,
        EXC_LOAD_PAGE      = 4'd13,
        EXC_RSVD_14        = 4'd14,
        EXC_STORE_PAGE     = 4'd15
    } exc_cause_e;

    // Machine interrupt codes, equal to their mie/mip bit positions
    typedef enum logic [3:0] {
        IRQ_SOFT  = 4'd3,
        IRQ_TIMER = 4'd7,
        IRQ_EXT   = 4'd11
    } irq_cause_e;

    // mtvec MODE field
    typedef enum logic [1:0] {
        DIRECT   = 2'd0,
        VECTORED = 2'd1
    } mtvec_mode_e;

endpackage

// ==== verilog/csr_read_mux.sv ====
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_read_mux
(
    input  csr_pkg::csr_addr_t    csr_rd_addr_i,
    csr_state_if.consumer         state_i,
    input  logic [`CSR_CNT_W-1:0] count_i,
    output csr_pkg::csr_word_t    csr_data_o
);
    import csr_pkg::*;

    csr_word_t mstatus_w;

    // mstatus view, MPP fixed to M-mode since no lower privilege exists
    always_comb
    begin
        mstatus_w        = '0;
        mstatus_w[12:11] = 2'b11;
        mstatus_w[7]     = state_i.mstatus_mpie;
        mstatus_w[3]     = state_i.mstatus_mie;
    end

    // --------------------
    // Address decode
    // --------------------
    always_comb
    begin
        case (csr_rd_addr_i)
            CSR_MSTATUS:   csr_data_o = mstatus_w;
            CSR_MIE:       csr_data_o = state_i.mie;
            CSR_MIP:       csr_data_o = state_i.mip;
            CSR_MTVEC:     csr_data_o = state_i.mtvec;
            CSR_MSCRATCH:  csr_data_o = state_i.mscratch;
            CSR_MEPC:      csr_data_o = state_i.mepc;
            CSR_MCAUSE:    csr_data_o = state_i.mcause;
            CSR_MTVAL:     csr_data_o = state_i.mtval;
            // Counter halves, user aliases share the machine counter
            CSR_MCYCLE,
            CSR_CYCLE:     csr_data_o = count_i[`CSR_XLEN-1:0];
            CSR_MCYCLEH,
            CSR_CYCLEH:    csr_data_o = count_i[`CSR_CNT_W-1:`CSR_XLEN];
            // Read-only IDs
            CSR_MVENDORID: csr_data_o = csr_word_t'(`CSR_VENDOR_ID);
            CSR_MARCHID:   csr_data_o = csr_word_t'(`CSR_ARCH_ID);
            CSR_MIMPID:    csr_data_o = csr_word_t'(`CSR_IMP_ID);
            CSR_MHARTID:   csr_data_o = csr_word_t'(`CSR_HART_ID);
            default:       csr_data_o = '0;
        endcase
    end

endmodule

// ==== verilog/csr_top.sv ====
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_top
(
    input  logic                clk_i,
    input  logic                rst_i,
    // Software read, combinational
    input  csr_pkg::csr_addr_t  csr_rd_addr_i,
    output csr_pkg::csr_word_t  csr_data_o,
    // Software write, applied at the next edge
    input  logic                csr_we_i,
    input  csr_pkg::csr_addr_t  csr_we_addr_i,
    input  csr_pkg::csr_word_t  csr_we_data_i,
    // Machine interrupt requests
    input  logic                ext_irq_i,
    input  logic                tmr_irq_i,
    input  logic                sft_irq_i,
    // Synchronous exception
    input  logic                exp_vld_i,
    input  csr_pkg::exc_cause_e exp_cause_i,
    input  csr_pkg::csr_word_t  exp_tval_i,
    // Trap entry and return
    input  csr_pkg::csr_word_t  next_pc_i,
    input  logic                mret_i,
    output logic                trap_taken_o,
    output csr_pkg::csr_word_t  handler_pc_o,
    output csr_pkg::csr_word_t  return_pc_o
);

    logic [`CSR_CNT_W-1:0] cycle_count;

    csr_state_if state_if ();
    csr_trap_if  trap_if ();

    // --------------------
    // Register state and trap record
    // --------------------
    csr_machine_regs i_machine_regs (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_we_i      (csr_we_i),
        .csr_we_addr_i (csr_we_addr_i),
        .csr_we_data_i (csr_we_data_i),
        .next_pc_i     (next_pc_i),
        .mret_i        (mret_i),
        .ext_irq_i     (ext_irq_i),
        .tmr_irq_i     (tmr_irq_i),
        .sft_irq_i     (sft_irq_i),
        .state_o       (state_if.producer),
        .trap_i        (trap_if.regs)
    );

    csr_trap_ctrl i_trap_ctrl (
        .ext_irq_i    (ext_irq_i),
        .tmr_irq_i    (tmr_irq_i),
        .sft_irq_i    (sft_irq_i),
        .exp_vld_i    (exp_vld_i),
        .exp_cause_i  (exp_cause_i),
        .exp_tval_i   (exp_tval_i),
        .state_i      (state_if.consumer),
        .trap_o       (trap_if.ctrl),
        .handler_pc_o (handler_pc_o)
    );

    csr_cycle_counter i_cycle_counter (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_we_i      (csr_we_i),
        .csr_we_addr_i (csr_we_addr_i),
        .csr_we_data_i (csr_we_data_i),
        .count_o       (cycle_count)
    );

    csr_read_mux i_read_mux (
        .csr_rd_addr_i (csr_rd_addr_i),
        .state_i       (state_if.consumer),
        .count_i       (cycle_count),
        .csr_data_o    (csr_data_o)
    );

    // mret target is the saved mepc
    assign trap_taken_o = trap_if.trap_taken;
    assign return_pc_o  = state_if.mepc;

endmodule

// ==== verilog/csr_trap_ctrl.sv ====
`timescale 1ns/10ps
`include "csr_cfg.svh"

module csr_trap_ctrl
(
    // Raw interrupt lines
    input  logic                ext_irq_i,
    input  logic                tmr_irq_i,
    input  logic                sft_irq_i,
    // Synchronous exception from the pipeline
    input  logic                exp_vld_i,
    input  csr_pkg::exc_cause_e exp_cause_i,
    input  csr_pkg::csr_word_t  exp_tval_i,
    csr_state_if.consumer       state_i,
    csr_trap_if.ctrl            trap_o,
    output csr_pkg::csr_word_t  handler_pc_o
);
    import csr_pkg::*;

    logic        irq_pend;
    irq_cause_e  irq_cause;
    mtvec_mode_e vec_mode;
    csr_word_t   vec_base;

    // --------------------
    // Interrupt priority
    // --------------------
    always_comb
    begin
        irq_pend  = 1'b0;
        irq_cause = IRQ_SOFT;
        // Global enable first, then external > timer > software
        if (state_i.mstatus_mie)
        begin
            if (ext_irq_i && state_i.mie[IRQ_EXT])
            begin
                irq_pend  = 1'b1;
                irq_cause = IRQ_EXT;
            end
            else if (tmr_irq_i && state_i.mie[IRQ_TIMER])
            begin
                irq_pend  = 1'b1;
                irq_cause = IRQ_TIMER;
            end
            else if (sft_irq_i && state_i.mie[IRQ_SOFT])
            begin
                irq_pend  = 1'b1;
                irq_cause = IRQ_SOFT;
            end
        end
    end

    // Exceptions always trap and override any interrupt
    assign trap_o.trap_taken = exp_vld_i || irq_pend;
    assign trap_o.trap_cause = exp_vld_i
        ? {1'b0, {(`CSR_XLEN-5){1'b0}}, exp_cause_i}
        : {1'b1, {(`CSR_XLEN-5){1'b0}}, irq_cause};

    // Faulting address is kept only for address-type causes
    assign trap_o.tval_we = exp_vld_i && (exp_cause_i inside {
        EXC_INSTR_MISALIGN, EXC_INSTR_FAULT, EXC_LOAD_MISALIGN, EXC_LOAD_FAULT,
        EXC_STORE_MISALIGN, EXC_STORE_FAULT, EXC_INSTR_PAGE, EXC_LOAD_PAGE,
        EXC_STORE_PAGE});
    assign trap_o.tval = exp_tval_i;

    // --------------------
    // Handler address
    // --------------------
    assign vec_mode = mtvec_mode_e'(state_i.mtvec[1:0]);
    assign vec_base = {state_i.mtvec[`CSR_XLEN-1:2], 2'b00};

    // Vectored mode offsets interrupts by 4*cause; reserved modes act as direct
    assign handler_pc_o = (vec_mode == VECTORED && irq_pend && !exp_vld_i)
        ? vec_base + (csr_word_t'(irq_cause) << 2)
        : vec_base;

    // An interrupt cause must be a machine code whose enable path was open
    always_comb
    begin
        if (trap_o.trap_taken && trap_o.trap_cause[`CSR_XLEN-1])
        begin
            a_irq_cause: assert (!exp_vld_i && state_i.mstatus_mie
                && (trap_o.trap_cause[3:0] inside {IRQ_SOFT, IRQ_TIMER, IRQ_EXT})
                && (trap_o.trap_cause[`CSR_XLEN-2:4] == '0)
                && state_i.mie[trap_o.trap_cause[3:0]])
            else $error("interrupt cause outside 3/7/11 or not enabled");
        end
    end

endmodule
